// ==== files.f ====
src/mcr_input_pkg.sv
src/ctrl_if.sv
src/spin_if.sv
src/game_input_decode.sv
src/spin_counter.sv
src/spinner_bank.sv
src/input_port_mux.sv
src/mcr_input_top.sv
sim/tb_mcr_input.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status gives the verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_mcr_input \
	-Mdir obj_dir -o tb_mcr_input \
	&& ./obj_dir/tb_mcr_input \
	|| { echo "simulation did not pass"; exit 1; }

// ==== sim/tb_mcr_input.sv ====
// Testbench for the player-input block with clock, reset, stimulus, reference model and checks
module tb_mcr_input;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 10;
	localparam int STEP_SHARED = 12;
	localparam int STEP_TIGER  = 25;
	localparam int STEP_WACKO  = 10;

	typedef struct packed {
		mcr_input_pkg::byte_t   in0;
		mcr_input_pkg::byte_t   in1;
		mcr_input_pkg::byte_t   in2;
		mcr_input_pkg::byte_t   in3;
		mcr_input_pkg::byte_t   in4;
		mcr_input_pkg::orient_t orient;
	} ports_t;

	logic                     clk_sys = 1'b0;
	logic                     reset;
	logic                     dl_wr;
	mcr_input_pkg::byte_t     dl_index;
	mcr_input_pkg::dl_addr_t  dl_addr;
	mcr_input_pkg::byte_t     dl_data;
	mcr_input_pkg::joy_word_t joy1;
	mcr_input_pkg::joy_word_t joy2;
	logic                     vsync;
	mcr_input_pkg::byte_t     input_0, input_1, input_2, input_3, input_4;
	mcr_input_pkg::orient_t   orientation;

	// Expected state of the DUT
	mcr_input_pkg::game_t     m_game;
	mcr_input_pkg::byte_t     m_dip0, m_dip1;
	mcr_input_pkg::spin_pos_t m_shared, m_angle1, m_angle2, m_wx, m_wy;

	integer seed;
	int     rnd;

	mcr_input_top dut_i (.*);

	initial begin
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ========================================
	// Failure reporting and waits
	// ========================================
	task automatic fail_value(input string msg);
		$display("[FAIL] time %0t: %s", $time, msg);
		$display("** FAIL **");
		$fatal(1, "output check failed");
	endtask

	task automatic fail_timeout(input string msg);
		$display("Timeout while %s", msg);
		$display("** FAIL **");
		$fatal(1, "wait timed out");
	endtask

	task automatic wait_cycles(input int n);
		int  count;
		time t_end;
		count = 0;
		t_end = $time + (n + 1) * CLK_PERIOD;
		while (count < n) begin
			@(negedge clk_sys);
			count++;
			if ($time > t_end)
				fail_timeout("waiting for falling clock edges");
		end
	endtask

	// ========================================
	// Reference model
	// ========================================
	function automatic mcr_input_pkg::game_t game_of(input mcr_input_pkg::byte_t code);
		if (code > 8'd5)
			return mcr_input_pkg::GAME_NONE;
		return mcr_input_pkg::game_t'(code[2:0]);
	endfunction

	// Wraps modulo 256, down wins over up
	function automatic mcr_input_pkg::spin_pos_t move(input mcr_input_pkg::spin_pos_t pos,
			input int step, input logic dn, input logic up);
		int v;
		v = int'(pos);
		if (dn)
			v = v - step;
		else if (up)
			v = v + step;
		return mcr_input_pkg::spin_pos_t'(v);
	endfunction

	function automatic mcr_input_pkg::byte_t axis(input logic lo, input logic hi);
		if (lo)
			return mcr_input_pkg::ANALOG_CENTRE - mcr_input_pkg::ANALOG_SWING;
		if (hi)
			return mcr_input_pkg::ANALOG_CENTRE + mcr_input_pkg::ANALOG_SWING;
		return mcr_input_pkg::ANALOG_CENTRE;
	endfunction

	function automatic ports_t ref_ports(input mcr_input_pkg::joy_word_t j1,
			input mcr_input_pkg::joy_word_t j2);
		mcr_input_pkg::joy_word_t a;
		ports_t                   p;
		logic                     fire;
		logic [3:0]               nib;
		logic [3:0]               dir;
		a = j1 | j2;
		p = '{8'hFF, 8'hFF, 8'hFF, m_dip0, 8'hFF, 2'b01};
		fire = 1'b0;
		// Down, up, right, left from the top bit
		dir = {a[mcr_input_pkg::JOY_DOWN], a[mcr_input_pkg::JOY_UP],
			a[mcr_input_pkg::JOY_RIGHT], a[mcr_input_pkg::JOY_LEFT]};
		case (m_game)
			mcr_input_pkg::GAME_SHOLLOW: begin
				p.orient = 2'b00;
				nib = {a[mcr_input_pkg::JOY_FIRE_A], a[mcr_input_pkg::JOY_FIRE_B],
					a[mcr_input_pkg::JOY_RIGHT], a[mcr_input_pkg::JOY_LEFT]};
				p.in1 = ~{nib, nib};
			end
			mcr_input_pkg::GAME_TRON: begin
				p.orient = 2'b00;
				fire = a[mcr_input_pkg::JOY_FIRE_A];
				p.in1 = ~(m_shared >> 1);
				p.in4 = ~(m_shared >> 1);
				p.in2 = ~{dir, dir};
				p.in3[7] = ~a[mcr_input_pkg::JOY_FIRE_A];
			end
			mcr_input_pkg::GAME_TWOTIGER: begin
				fire = a[mcr_input_pkg::JOY_FIRE_C];
				p.in1 = ~(m_angle1 >> 1);
				p.in4 = ~(m_angle2 >> 1);
				p.in2 = ~{4'b0000, j2[mcr_input_pkg::JOY_FIRE_B], j2[mcr_input_pkg::JOY_FIRE_A],
					j1[mcr_input_pkg::JOY_FIRE_B], j1[mcr_input_pkg::JOY_FIRE_A]};
			end
			mcr_input_pkg::GAME_WACKO: begin
				p.in1 = m_wx;
				p.in2 = m_wy;
				nib = {a[mcr_input_pkg::JOY_FIRE_C], a[mcr_input_pkg::JOY_FIRE_B],
					a[mcr_input_pkg::JOY_FIRE_D], a[mcr_input_pkg::JOY_FIRE_A]};
				p.in4 = ~{nib, nib};
			end
			mcr_input_pkg::GAME_KROOZR: begin
				fire = a[mcr_input_pkg::JOY_FIRE_A];
				p.in1 = ~{a[mcr_input_pkg::JOY_FIRE_B], m_shared[7], 3'b111, m_shared[6:4]};
				p.in2 = axis(a[mcr_input_pkg::JOY_LEFT], a[mcr_input_pkg::JOY_RIGHT]);
				p.in4 = axis(a[mcr_input_pkg::JOY_UP], a[mcr_input_pkg::JOY_DOWN]);
			end
			mcr_input_pkg::GAME_DOMINO: begin
				fire = a[mcr_input_pkg::JOY_FIRE_A];
				p.in1 = ~{4'b0000, dir};
				p.in2 = ~{3'b000, a[mcr_input_pkg::JOY_FIRE_A], dir};
			end
			default: begin
				p.orient = 2'b00;
			end
		endcase
		// Active-low coin, start and service bits
		p.in0[7] = ~m_dip1[0];
		p.in0[4] = ~fire;
		p.in0[3] = ~a[mcr_input_pkg::JOY_START2];
		p.in0[2] = ~a[mcr_input_pkg::JOY_START1];
		p.in0[0] = ~a[mcr_input_pkg::JOY_COIN];
		return p;
	endfunction

	task automatic step_model(input mcr_input_pkg::joy_word_t j1,
			input mcr_input_pkg::joy_word_t j2);
		mcr_input_pkg::joy_word_t a;
		a = j1 | j2;
		m_shared = move(m_shared, STEP_SHARED, a[mcr_input_pkg::JOY_RCCW],
			a[mcr_input_pkg::JOY_RCW]);
		m_angle1 = move(m_angle1, STEP_TIGER,
			j1[mcr_input_pkg::JOY_RCCW] | j1[mcr_input_pkg::JOY_LEFT],
			j1[mcr_input_pkg::JOY_RCW] | j1[mcr_input_pkg::JOY_RIGHT]);
		m_angle2 = move(m_angle2, STEP_TIGER,
			j2[mcr_input_pkg::JOY_RCCW] | j2[mcr_input_pkg::JOY_LEFT],
			j2[mcr_input_pkg::JOY_RCW] | j2[mcr_input_pkg::JOY_RIGHT]);
		m_wx = move(m_wx, STEP_WACKO, a[mcr_input_pkg::JOY_LEFT], a[mcr_input_pkg::JOY_RIGHT]);
		m_wy = move(m_wy, STEP_WACKO, a[mcr_input_pkg::JOY_DOWN], a[mcr_input_pkg::JOY_UP]);
	endtask

	// ========================================
	// Checks
	// ========================================
	task automatic check_port(input string name, input mcr_input_pkg::byte_t got,
			input mcr_input_pkg::byte_t exp);
		if (got !== exp)
			fail_value($sformatf("%s in %s: got %h, expected %h", name, m_game.name(), got, exp));
	endtask

	task automatic check_orient(input mcr_input_pkg::orient_t got,
			input mcr_input_pkg::orient_t exp);
		if (got !== exp)
			fail_value($sformatf("orientation in %s: got %b, expected %b",
				m_game.name(), got, exp));
	endtask

	task automatic compare_outputs();
		ports_t exp;
		exp = ref_ports(joy1, joy2);
		check_port("input_0", input_0, exp.in0);
		check_port("input_1", input_1, exp.in1);
		check_port("input_2", input_2, exp.in2);
		check_port("input_3", input_3, exp.in3);
		check_port("input_4", input_4, exp.in4);
		check_orient(orientation, exp.orient);
	endtask

	// ========================================
	// Stimulus
	// ========================================
	task automatic write_and_check(input mcr_input_pkg::byte_t index,
			input mcr_input_pkg::dl_addr_t addr, input mcr_input_pkg::byte_t data);
		dl_wr    = 1'b1;
		dl_index = index;
		dl_addr  = addr;
		dl_data  = data;
		if (index == mcr_input_pkg::DL_INDEX_GAME)
			m_game = game_of(data);
		else if (index == mcr_input_pkg::DL_INDEX_DIP && addr == 16'd0)
			m_dip0 = data;
		else if (index == mcr_input_pkg::DL_INDEX_DIP && addr == 16'd1)
			m_dip1 = data;
		wait_cycles(1);
		dl_wr = 1'b0;
		wait_cycles(2);
		compare_outputs();
	endtask

	task automatic hold_joy(input mcr_input_pkg::joy_word_t j1,
			input mcr_input_pkg::joy_word_t j2);
		joy1 = j1;
		joy2 = j2;
		wait_cycles(3);
		compare_outputs();
	endtask

	// Controls settle before the first vsync rise of the series
	task automatic vsync_series(input mcr_input_pkg::joy_word_t j1,
			input mcr_input_pkg::joy_word_t j2, input int n);
		hold_joy(j1, j2);
		for (int i = 0; i < n; i++) begin
			vsync = 1'b1;
			step_model(j1, j2);
			wait_cycles(1);
			vsync = 1'b0;
			wait_cycles(2);
			compare_outputs();
		end
	endtask

	initial begin
		seed     = 32'h6806044a;
		reset    = 1'b1;
		dl_wr    = 1'b0;
		dl_index = '0;
		dl_addr  = '0;
		dl_data  = '0;
		joy1     = '0;
		joy2     = '0;
		vsync    = 1'b0;
		m_game   = mcr_input_pkg::GAME_SHOLLOW;
		m_dip0   = '0;
		m_dip1   = '0;
		m_shared = '0;
		m_angle1 = '0;
		m_angle2 = '0;
		m_wx     = '0;
		m_wy     = '0;
		wait_cycles(2);
		reset = 1'b0;
		wait_cycles(1);
		compare_outputs();

		// Idle ports for every game code and one unknown code
		for (int c = 0; c < 6; c++)
			write_and_check(mcr_input_pkg::DL_INDEX_GAME, 16'd0, mcr_input_pkg::byte_t'(c));
		write_and_check(mcr_input_pkg::DL_INDEX_GAME, 16'd0, 8'd9);

		// DIP bytes, then writes that must be ignored
		write_and_check(mcr_input_pkg::DL_INDEX_DIP, 16'd0, 8'hA5);
		write_and_check(mcr_input_pkg::DL_INDEX_DIP, 16'd1, 8'h01);
		write_and_check(8'd7, 16'd0, 8'h3C);
		write_and_check(mcr_input_pkg::DL_INDEX_DIP, 16'd2, 8'h3C);
		write_and_check(mcr_input_pkg::DL_INDEX_DIP, 16'h0100, 8'h3C);
		write_and_check(mcr_input_pkg::DL_INDEX_DIP, 16'd1, 8'hFE);

		// Position counters across vsync pulses
		write_and_check(mcr_input_pkg::DL_INDEX_GAME, 16'd0, 8'd1);
		vsync_series(16'h0100, 16'h0000, 12);
		vsync_series(16'h0000, 16'h0200, 12);
		vsync_series(16'h0300, 16'h0000, 6);
		write_and_check(mcr_input_pkg::DL_INDEX_GAME, 16'd0, 8'd2);
		vsync_series(16'h0001, 16'h0002, 12);
		vsync_series(16'h0200, 16'h0100, 12);
		vsync_series(16'h0003, 16'h0300, 6);
		write_and_check(mcr_input_pkg::DL_INDEX_GAME, 16'd0, 8'd3);
		vsync_series(16'h0009, 16'h0000, 12);
		vsync_series(16'h0002, 16'h0004, 12);
		vsync_series(16'h0003, 16'h000C, 6);
		hold_joy(16'h0000, 16'h0000);

		// Random joystick pairs for each game
		for (int c = 0; c < 7; c++) begin
			write_and_check(mcr_input_pkg::DL_INDEX_GAME, 16'd0,
				(c == 6) ? 8'd9 : mcr_input_pkg::byte_t'(c));
			for (int i = 0; i < 20; i++) begin
				rnd = $random(seed);
				hold_joy(rnd[15:0], rnd[31:16]);
			end
			hold_joy(16'h0000, 16'h0000);
		end

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== src/mcr_input_top.sv ====
// Top level of the player-input block: download decode, spinner bank and port assembly
module mcr_input_top #(
	parameter int SPIN_STEP_SHARED = 12,
	parameter int SPIN_STEP_TIGER  = 25,
	parameter int SPIN_STEP_WACKO  = 10
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     dl_wr,
	input  mcr_input_pkg::byte_t     dl_index,
	input  mcr_input_pkg::dl_addr_t  dl_addr,
	input  mcr_input_pkg::byte_t     dl_data,
	input  mcr_input_pkg::joy_word_t joy1,
	input  mcr_input_pkg::joy_word_t joy2,
	input  logic                     vsync,
	output mcr_input_pkg::byte_t     input_0,
	output mcr_input_pkg::byte_t     input_1,
	output mcr_input_pkg::byte_t     input_2,
	output mcr_input_pkg::byte_t     input_3,
	output mcr_input_pkg::byte_t     input_4,
	output mcr_input_pkg::orient_t   orientation
);

	ctrl_if ctrl ();
	spin_if spin ();

	game_input_decode decode_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.joy1     (joy1),
		.joy2     (joy2),
		.ctrl     (ctrl.decode)
	);

	spinner_bank #(
		.SPIN_STEP_SHARED (SPIN_STEP_SHARED),
		.SPIN_STEP_TIGER  (SPIN_STEP_TIGER),
		.SPIN_STEP_WACKO  (SPIN_STEP_WACKO)
	) bank_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync   (vsync),
		.ctrl    (ctrl.user),
		.spin    (spin.bank)
	);

	input_port_mux mux_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ctrl        (ctrl.user),
		.spin        (spin.mux),
		.input_0     (input_0),
		.input_1     (input_1),
		.input_2     (input_2),
		.input_3     (input_3),
		.input_4     (input_4),
		.orientation (orientation)
	);

endmodule

// ==== src/input_port_mux.sv ====
// Per-game assembly of the five active-low input ports and the screen orientation
module input_port_mux (
	input  logic                     clk_sys,
	input  logic                     reset,
	ctrl_if.user                     ctrl,
	spin_if.mux                      spin,
	output mcr_input_pkg::byte_t     input_0,
	output mcr_input_pkg::byte_t     input_1,
	output mcr_input_pkg::byte_t     input_2,
	output mcr_input_pkg::byte_t     input_3,
	output mcr_input_pkg::byte_t     input_4,
	output mcr_input_pkg::orient_t   orientation
);

	// Merged controls
	logic m_right, m_left, m_down, m_up;
	logic m_fire_a, m_fire_b, m_fire_c, m_fire_d;
	logic m_start1, m_start2, m_coin;
	logic fire_sel;

	mcr_input_pkg::byte_t   n_in0, n_in1, n_in2, n_in3, n_in4;
	mcr_input_pkg::orient_t n_orient;

	assign m_right  = ctrl.any[mcr_input_pkg::JOY_RIGHT];
	assign m_left   = ctrl.any[mcr_input_pkg::JOY_LEFT];
	assign m_down   = ctrl.any[mcr_input_pkg::JOY_DOWN];
	assign m_up     = ctrl.any[mcr_input_pkg::JOY_UP];
	assign m_fire_a = ctrl.any[mcr_input_pkg::JOY_FIRE_A];
	assign m_fire_b = ctrl.any[mcr_input_pkg::JOY_FIRE_B];
	assign m_fire_c = ctrl.any[mcr_input_pkg::JOY_FIRE_C];
	assign m_fire_d = ctrl.any[mcr_input_pkg::JOY_FIRE_D];
	assign m_start1 = ctrl.any[mcr_input_pkg::JOY_START1];
	assign m_start2 = ctrl.any[mcr_input_pkg::JOY_START2];
	assign m_coin   = ctrl.any[mcr_input_pkg::JOY_COIN];

	// ========================================
	// Port selection
	// ========================================
	always_comb begin
		n_orient = 2'b00;
		n_in1    = 8'hFF;
		n_in2    = 8'hFF;
		n_in3    = ctrl.dip0;
		n_in4    = 8'hFF;
		fire_sel = 1'b0;

		case (ctrl.game)
			mcr_input_pkg::GAME_SHOLLOW: begin
				n_in1 = ~{2{m_fire_a, m_fire_b, m_right, m_left}};
			end
			mcr_input_pkg::GAME_TRON: begin
				fire_sel = m_fire_a;
				n_in1    = ~{1'b0, spin.shared[7:1]};
				n_in2    = ~{2{m_down, m_up, m_right, m_left}};
				n_in3[7] = ~m_fire_a;
				n_in4    = ~{1'b0, spin.shared[7:1]};
			end
			mcr_input_pkg::GAME_TWOTIGER: begin
				n_orient = 2'b01;
				fire_sel = m_fire_c;
				n_in1    = ~{1'b0, spin.angle1[7:1]};
				n_in2    = ~{4'b0000,
					ctrl.p2[mcr_input_pkg::JOY_FIRE_B], ctrl.p2[mcr_input_pkg::JOY_FIRE_A],
					ctrl.p1[mcr_input_pkg::JOY_FIRE_B], ctrl.p1[mcr_input_pkg::JOY_FIRE_A]};
				n_in4    = ~{1'b0, spin.angle2[7:1]};
			end
			mcr_input_pkg::GAME_WACKO: begin
				n_orient = 2'b01;
				n_in1    = spin.wx;
				n_in2    = spin.wy;
				n_in4    = ~{2{m_fire_c, m_fire_b, m_fire_d, m_fire_a}};
			end
			mcr_input_pkg::GAME_KROOZR: begin
				n_orient = 2'b01;
				fire_sel = m_fire_a;
				n_in1    = ~{m_fire_b, spin.shared[7], 3'b111, spin.shared[6:4]};
				// Stick axes are absolute around a fixed centre
				if (m_left)
					n_in2 = mcr_input_pkg::ANALOG_CENTRE - mcr_input_pkg::ANALOG_SWING;
				else if (m_right)
					n_in2 = mcr_input_pkg::ANALOG_CENTRE + mcr_input_pkg::ANALOG_SWING;
				else
					n_in2 = mcr_input_pkg::ANALOG_CENTRE;
				if (m_up)
					n_in4 = mcr_input_pkg::ANALOG_CENTRE - mcr_input_pkg::ANALOG_SWING;
				else if (m_down)
					n_in4 = mcr_input_pkg::ANALOG_CENTRE + mcr_input_pkg::ANALOG_SWING;
				else
					n_in4 = mcr_input_pkg::ANALOG_CENTRE;
			end
			mcr_input_pkg::GAME_DOMINO: begin
				n_orient = 2'b01;
				fire_sel = m_fire_a;
				n_in1    = ~{4'b0000, m_down, m_up, m_right, m_left};
				n_in2    = ~{3'b000, m_fire_a, m_down, m_up, m_right, m_left};
			end
			default: begin
				n_orient = 2'b00;
			end
		endcase

		// Coin, start and service layout is common to all games
		n_in0 = ~{ctrl.service, 1'b0, 1'b0, fire_sel, m_start2, m_start1, 1'b0, m_coin};
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			input_0     <= 8'hFF;
			input_1     <= 8'hFF;
			input_2     <= 8'hFF;
			input_3     <= 8'h00;
			input_4     <= 8'hFF;
			orientation <= 2'b00;
		end else begin
			input_0     <= n_in0;
			input_1     <= n_in1;
			input_2     <= n_in2;
			input_3     <= n_in3;
			input_4     <= n_in4;
			orientation <= n_orient;
		end
	end

endmodule

// ==== src/spinner_bank.sv ====
// Bank of five rotary counters with per-game control selection
module spinner_bank #(
	parameter int SPIN_STEP_SHARED = 12,
	parameter int SPIN_STEP_TIGER  = 25,
	parameter int SPIN_STEP_WACKO  = 10
) (
	input  logic   clk_sys,
	input  logic   reset,
	input  logic   vsync,
	ctrl_if.user   ctrl,
	spin_if.bank   spin
);

	// Tron and Kroozr dial from the merged rotate buttons
	spin_counter #(.STEP(SPIN_STEP_SHARED)) shared_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync   (vsync),
		.minus   (ctrl.any[mcr_input_pkg::JOY_RCCW]),
		.plus    (ctrl.any[mcr_input_pkg::JOY_RCW]),
		.pos     (spin.shared)
	);

	// ========================================
	// Two Tigers, one aim per player
	// ========================================
	spin_counter #(.STEP(SPIN_STEP_TIGER)) angle1_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync   (vsync),
		.minus   (ctrl.p1[mcr_input_pkg::JOY_RCCW] | ctrl.p1[mcr_input_pkg::JOY_LEFT]),
		.plus    (ctrl.p1[mcr_input_pkg::JOY_RCW] | ctrl.p1[mcr_input_pkg::JOY_RIGHT]),
		.pos     (spin.angle1)
	);

	spin_counter #(.STEP(SPIN_STEP_TIGER)) angle2_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync   (vsync),
		.minus   (ctrl.p2[mcr_input_pkg::JOY_RCCW] | ctrl.p2[mcr_input_pkg::JOY_LEFT]),
		.plus    (ctrl.p2[mcr_input_pkg::JOY_RCW] | ctrl.p2[mcr_input_pkg::JOY_RIGHT]),
		.pos     (spin.angle2)
	);

	// ========================================
	// Wacko trackball from the merged stick
	// ========================================
	spin_counter #(.STEP(SPIN_STEP_WACKO)) wx_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync   (vsync),
		.minus   (ctrl.any[mcr_input_pkg::JOY_LEFT]),
		.plus    (ctrl.any[mcr_input_pkg::JOY_RIGHT]),
		.pos     (spin.wx)
	);

	spin_counter #(.STEP(SPIN_STEP_WACKO)) wy_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync   (vsync),
		.minus   (ctrl.any[mcr_input_pkg::JOY_DOWN]),
		.plus    (ctrl.any[mcr_input_pkg::JOY_UP]),
		.pos     (spin.wy)
	);

endmodule

// ==== src/spin_counter.sv ====
// Wrapping position counter stepped once per vertical sync rising edge
module spin_counter #(
	parameter int STEP = 1
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      vsync,
	input  logic                      minus,
	input  logic                      plus,
	output mcr_input_pkg::spin_pos_t  pos
);

	localparam mcr_input_pkg::spin_pos_t STEP_V = mcr_input_pkg::spin_pos_t'(STEP);

	logic                     vsync_q;
	logic                     vs_rise;
	mcr_input_pkg::spin_pos_t pos_q;

	assign vs_rise = vsync && !vsync_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vsync_q <= 1'b0;
			pos_q   <= '0;
		end else begin
			vsync_q <= vsync;
			// Minus has priority when both directions are held
			if (vs_rise) begin
				if (minus)
					pos_q <= pos_q - STEP_V;
				else if (plus)
					pos_q <= pos_q + STEP_V;
			end
		end
	end

	assign pos = pos_q;

	a_pos_on_vsync: assert property (@(posedge clk_sys) disable iff (reset)
		!vs_rise |=> $stable(pos_q))
		else $error("position moved without a vsync rising edge");

endmodule

// ==== src/game_input_decode.sv ====
// Download decoder for game code and DIP bytes, joystick registers and merged controls
module game_input_decode (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     dl_wr,
	input  mcr_input_pkg::byte_t     dl_index,
	input  mcr_input_pkg::dl_addr_t  dl_addr,
	input  mcr_input_pkg::byte_t     dl_data,
	input  mcr_input_pkg::joy_word_t joy1,
	input  mcr_input_pkg::joy_word_t joy2,
	ctrl_if.decode                   ctrl
);

	mcr_input_pkg::byte_t     code_q;
	mcr_input_pkg::game_t     game_q;
	mcr_input_pkg::byte_t     dip0_q;
	mcr_input_pkg::byte_t     dip1_q;
	mcr_input_pkg::joy_word_t p1_q;
	mcr_input_pkg::joy_word_t p2_q;

	logic wr_game;
	logic wr_dip0;
	logic wr_dip1;

	// Codes past the known set select no game
	function automatic mcr_input_pkg::game_t code_to_game(input mcr_input_pkg::byte_t code);
		case (code)
			8'd0:    return mcr_input_pkg::GAME_SHOLLOW;
			8'd1:    return mcr_input_pkg::GAME_TRON;
			8'd2:    return mcr_input_pkg::GAME_TWOTIGER;
			8'd3:    return mcr_input_pkg::GAME_WACKO;
			8'd4:    return mcr_input_pkg::GAME_KROOZR;
			8'd5:    return mcr_input_pkg::GAME_DOMINO;
			default: return mcr_input_pkg::GAME_NONE;
		endcase
	endfunction

	// ========================================
	// Download writes
	// ========================================
	assign wr_game = dl_wr && (dl_index == mcr_input_pkg::DL_INDEX_GAME);
	assign wr_dip0 = dl_wr && (dl_index == mcr_input_pkg::DL_INDEX_DIP) && (dl_addr == 16'd0);
	assign wr_dip1 = dl_wr && (dl_index == mcr_input_pkg::DL_INDEX_DIP) && (dl_addr == 16'd1);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_q <= '0;
			game_q <= mcr_input_pkg::GAME_SHOLLOW;
			dip0_q <= '0;
			dip1_q <= '0;
			p1_q   <= '0;
			p2_q   <= '0;
		end else begin
			if (wr_game)
				code_q <= dl_data;
			// Game decode sits one stage behind the code register
			game_q <= code_to_game(code_q);
			if (wr_dip0)
				dip0_q <= dl_data;
			if (wr_dip1)
				dip1_q <= dl_data;
			p1_q <= joy1;
			p2_q <= joy2;
		end
	end

	assign ctrl.p1      = p1_q;
	assign ctrl.p2      = p2_q;
	assign ctrl.any     = p1_q | p2_q;
	assign ctrl.service = dip1_q[0];
	assign ctrl.dip0    = dip0_q;
	assign ctrl.game    = game_q;

	// Unknown codes reach the game as GAME_NONE two edges after the write
	a_game_legal: assert property (@(posedge clk_sys) disable iff (reset)
		wr_game |-> ##2
			((game_q == mcr_input_pkg::GAME_NONE) == ($past(dl_data, 2) > 8'd5)))
		else $error("game does not follow the written code");

endmodule

// ==== src/spin_if.sv ====
// Interface for the five rotary position values
interface spin_if;

	// Tron and Kroozr dial
	mcr_input_pkg::spin_pos_t shared;

	// Two Tigers aim per player
	mcr_input_pkg::spin_pos_t angle1;
	mcr_input_pkg::spin_pos_t angle2;

	// Wacko trackball axes
	mcr_input_pkg::spin_pos_t wx;
	mcr_input_pkg::spin_pos_t wy;

	modport bank (output shared, angle1, angle2, wx, wy);

	modport mux (input shared, angle1, angle2, wx, wy);

endinterface

// ==== src/ctrl_if.sv ====
// Interface for the registered player controls, merged controls, DIP values and game
interface ctrl_if;

	// Registered joysticks and their bitwise OR
	mcr_input_pkg::joy_word_t p1;
	mcr_input_pkg::joy_word_t p2;
	mcr_input_pkg::joy_word_t any;

	// Service switch and DIP byte 0
	logic                     service;
	mcr_input_pkg::byte_t     dip0;

	mcr_input_pkg::game_t     game;

	modport decode (output p1, p2, any, service, dip0, game);

	modport user (input p1, p2, any, service, dip0, game);

endinterface

// ==== src/mcr_input_pkg.sv ====
// Shared widths, typedefs, game enum, download index codes and joystick bit positions
package mcr_input_pkg;

	// ========================================
	// Data widths
	// ========================================
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] dl_addr_t;
	typedef logic [15:0] joy_word_t;
	typedef logic [7:0]  spin_pos_t;

	// Bit 0 set means landscape, bit 1 unused by this game set
	typedef logic [1:0]  orient_t;

	// ========================================
	// Game selection
	// ========================================
	typedef enum logic [2:0] {
		GAME_SHOLLOW  = 3'd0,
		GAME_TRON     = 3'd1,
		GAME_TWOTIGER = 3'd2,
		GAME_WACKO    = 3'd3,
		GAME_KROOZR   = 3'd4,
		GAME_DOMINO   = 3'd5,
		GAME_NONE     = 3'd7
	} game_t;

	// Download index values
	localparam byte_t DL_INDEX_GAME = 8'd1;
	localparam byte_t DL_INDEX_DIP  = 8'd254;

	// ========================================
	// Joystick word bit positions
	// ========================================
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_FIRE_C = 6;
	localparam int JOY_FIRE_D = 7;
	localparam int JOY_RCW    = 8;
	localparam int JOY_RCCW   = 9;
	localparam int JOY_START1 = 10;
	localparam int JOY_START2 = 11;
	localparam int JOY_COIN   = 12;

	// Kroozr stick rests at the centre and swings by a fixed amount
	localparam byte_t ANALOG_CENTRE = 8'd100;
	localparam byte_t ANALOG_SWING  = 8'd63;

endpackage
